/* Makefile */
# Verilator build and run for the SH7034 peripheral subset

VERILATOR  ?= verilator
TOP        ?= sh_periph_tb
RTL_TOP    ?= sh_periph_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FILELIST))
RTL_SRC := $(filter hw/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRC)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
hw/sh_periph_pkg.sv
hw/sh_clock_reset.sv
hw/sh_ibus_ctrl.sv
hw/sh_itu_timer.sv
hw/sh_wdt.sv
hw/sh_intc.sv
hw/sh_periph_top.sv
sim/sh_periph_tb.sv

/* hw/sh_clock_reset.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_clock_reset (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 res_n,
	output logic                 res_sync_n,
	output sh_periph_pkg::tick_t ticks
);
	import sh_periph_pkg::*;

	logic [12:0] div_cnt;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			res_sync_n <= 1'b0;
		end else begin
			res_sync_n <= res_n;
		end
	end

	// Free-running divider, tick fires after low k bits are all ones
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			ticks   <= '0;
		end else begin
			div_cnt               <= div_cnt + 13'd1;
			ticks[TICK_DIV2]    <= div_cnt[0];
			ticks[TICK_DIV4]    <= &div_cnt[1:0];
			ticks[TICK_DIV8]    <= &div_cnt[2:0];
			ticks[TICK_DIV64]   <= &div_cnt[5:0];
			ticks[TICK_DIV256]  <= &div_cnt[7:0];
			ticks[TICK_DIV1024] <= &div_cnt[9:0];
			ticks[TICK_DIV8192] <= &div_cnt[12:0];
		end
	end

endmodule

`default_nettype wire

/* hw/sh_ibus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_ibus_ctrl (
	input  logic                                CLK,
	input  logic                                RST_N,
	input  logic                                ibus_req,
	input  logic                                ibus_we,
	input  logic [sh_periph_pkg::ADDR_W-1:0]    ibus_addr,
	input  logic [sh_periph_pkg::DATA_W-1:0]    ibus_wdata,
	input  logic [sh_periph_pkg::DATA_W-1:0]    itu_rdata,
	input  logic [sh_periph_pkg::DATA_W-1:0]    intc_rdata,
	input  logic [sh_periph_pkg::DATA_W-1:0]    wdt_rdata,
	output logic [sh_periph_pkg::DATA_W-1:0]    ibus_rdata,
	output logic [sh_periph_pkg::REG_IDX_W-1:0] reg_idx,
	output logic [sh_periph_pkg::DATA_W-1:0]    wdata,
	output logic                                itu_rd,
	output logic                                itu_wr,
	output logic                                intc_rd,
	output logic                                intc_wr,
	output logic                                wdt_rd,
	output logic                                wdt_wr
);
	import sh_periph_pkg::*;

	periph_sel_t sel;
	periph_sel_t rd_sel;
	logic        rd_req;
	logic        wr_req;

	always_comb begin
		sel = SEL_NONE;
		if (ibus_addr[ADDR_W-1:4] == ITU_BASE[ADDR_W-1:4]) begin
			sel = SEL_ITU;
		end else if (ibus_addr[ADDR_W-1:4] == INTC_BASE[ADDR_W-1:4]) begin
			sel = SEL_INTC;
		end else if (ibus_addr[ADDR_W-1:4] == WDT_BASE[ADDR_W-1:4]) begin
			sel = SEL_WDT;
		end
	end

	assign rd_req  = ibus_req & ~ibus_we;
	assign wr_req  = ibus_req & ibus_we;
	assign reg_idx = ibus_addr[3:2];
	assign wdata   = ibus_wdata;

	assign itu_rd  = rd_req & (sel == SEL_ITU);
	assign itu_wr  = wr_req & (sel == SEL_ITU);
	assign intc_rd = rd_req & (sel == SEL_INTC);
	assign intc_wr = wr_req & (sel == SEL_INTC);
	assign wdt_rd  = rd_req & (sel == SEL_WDT);
	assign wdt_wr  = wr_req & (sel == SEL_WDT);

	// Remembers which block answers the last read
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd_sel <= SEL_NONE;
		end else if (rd_req) begin
			rd_sel <= sel;
		end
	end

	always_comb begin
		case (rd_sel)
			SEL_ITU:  ibus_rdata = itu_rdata;
			SEL_INTC: ibus_rdata = intc_rdata;
			SEL_WDT:  ibus_rdata = wdt_rdata;
			default:  ibus_rdata = '0;
		endcase
	end

	a_one_strobe: assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({itu_rd, itu_wr, intc_rd, intc_wr, wdt_rd, wdt_wr}));

endmodule

`default_nettype wire

/* hw/sh_intc.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_intc (
	input  logic                                CLK,
	input  logic                                RST_N,
	input  logic                                res_sync_n,
	input  logic                                rd,
	input  logic                                wr,
	input  logic [sh_periph_pkg::REG_IDX_W-1:0] reg_idx,
	input  logic [sh_periph_pkg::DATA_W-1:0]    wdata,
	input  logic                                imia_irq,
	input  logic                                ovi_irq,
	input  logic                                iti_irq,
	input  logic [sh_periph_pkg::LVL_W-1:0]     int_mask,
	output logic [sh_periph_pkg::DATA_W-1:0]    rdata,
	output logic                                int_req,
	output logic [sh_periph_pkg::LVL_W-1:0]     int_lvl,
	output logic [sh_periph_pkg::VEC_W-1:0]     int_vec
);
	import sh_periph_pkg::*;

	logic [15:0]      ipr;
	logic [LVL_W-1:0] itu_lvl;
	logic [LVL_W-1:0] wdt_lvl;
	logic             nxt_req;
	logic [LVL_W-1:0] nxt_lvl;
	logic [VEC_W-1:0] nxt_vec;

	assign itu_lvl = ipr[15:12];
	assign wdt_lvl = ipr[11:8];

	// Ties go to IMIA, then OVI, then ITI
	always_comb begin
		nxt_req = 1'b0;
		nxt_lvl = '0;
		nxt_vec = '0;
		if ((imia_irq || ovi_irq) && itu_lvl > int_mask) begin
			nxt_req = 1'b1;
			nxt_lvl = itu_lvl;
			nxt_vec = imia_irq ? VEC_IMIA : VEC_OVI;
		end
		if (iti_irq && wdt_lvl > int_mask && (!nxt_req || wdt_lvl > nxt_lvl)) begin
			nxt_req = 1'b1;
			nxt_lvl = wdt_lvl;
			nxt_vec = VEC_ITI;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ipr     <= '0;
			int_req <= 1'b0;
			int_lvl <= '0;
			int_vec <= '0;
		end else if (!res_sync_n) begin
			ipr     <= '0;
			int_req <= 1'b0;
			int_lvl <= '0;
			int_vec <= '0;
		end else begin
			if (wr && reg_idx == INTC_IPR) begin
				ipr <= wdata[15:0];
			end
			int_req <= nxt_req;
			int_lvl <= nxt_lvl;
			int_vec <= nxt_vec;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd) begin
			rdata <= (reg_idx == INTC_IPR) ? {16'h0000, ipr} : '0;
		end
	end

	a_lvl_above_mask: assert property (@(posedge CLK) disable iff (!RST_N)
		int_req |-> int_lvl > $past(int_mask));

endmodule

`default_nettype wire

/* hw/sh_itu_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_itu_timer (
	input  logic                                CLK,
	input  logic                                RST_N,
	input  logic                                res_sync_n,
	input  sh_periph_pkg::tick_t                ticks,
	input  logic                                rd,
	input  logic                                wr,
	input  logic [sh_periph_pkg::REG_IDX_W-1:0] reg_idx,
	input  logic [sh_periph_pkg::DATA_W-1:0]    wdata,
	output logic [sh_periph_pkg::DATA_W-1:0]    rdata,
	output logic                                imia_irq,
	output logic                                ovi_irq
);
	import sh_periph_pkg::*;

	logic [5:0]        tcr;
	logic              imfa;
	logic              ovf;
	logic [TCNT_W-1:0] tcnt;
	logic [TCNT_W-1:0] gra;
	logic              cclr;
	logic              start;
	logic              tick_en;
	logic              count;
	logic              cmp_a;
	logic [DATA_W-1:0] rd_mux;

	assign cclr  = tcr[2];
	assign start = tcr[3];

	always_comb begin
		case (tcr[1:0])
			2'd0:    tick_en = 1'b1;
			2'd1:    tick_en = ticks[TICK_DIV2];
			2'd2:    tick_en = ticks[TICK_DIV4];
			default: tick_en = ticks[TICK_DIV8];
		endcase
	end

	assign count = start & tick_en;
	assign cmp_a = (tcnt == gra);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tcr  <= '0;
			imfa <= 1'b0;
			ovf  <= 1'b0;
			tcnt <= '0;
			gra  <= '1;
		end else if (!res_sync_n) begin
			tcr  <= '0;
			imfa <= 1'b0;
			ovf  <= 1'b0;
			tcnt <= '0;
			gra  <= '1;
		end else begin
			if (wr && reg_idx == ITU_TCR) begin
				tcr <= wdata[5:0];
			end
			if (wr && reg_idx == ITU_GRA) begin
				gra <= wdata[TCNT_W-1:0];
			end
			// Flags clear on a written 0 only
			if (wr && reg_idx == ITU_TSR) begin
				imfa <= imfa & wdata[0];
				ovf  <= ovf & wdata[1];
			end
			if (wr && reg_idx == ITU_TCNT) begin
				tcnt <= wdata[TCNT_W-1:0];
			end else if (count) begin
				tcnt <= (cmp_a && cclr) ? '0 : tcnt + 1'b1;
			end
			// Events win over a clearing write in the same cycle
			if (count && cmp_a) begin
				imfa <= 1'b1;
			end
			if (count && !(cmp_a && cclr) && &tcnt) begin
				ovf <= 1'b1;
			end
		end
	end

	always_comb begin
		rd_mux = '0;
		case (reg_idx)
			ITU_TCR:  rd_mux[5:0] = tcr;
			ITU_TSR:  rd_mux[1:0] = {ovf, imfa};
			ITU_TCNT: rd_mux[TCNT_W-1:0] = tcnt;
			default:  rd_mux[TCNT_W-1:0] = gra;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rd) begin
			rdata <= rd_mux;
		end
	end

	assign imia_irq = imfa & tcr[4];
	assign ovi_irq  = ovf & tcr[5];

	a_imfa_needs_start: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(imfa) |-> $past(start));

endmodule

`default_nettype wire

/* hw/sh_periph_pkg.sv */
`default_nettype none

package sh_periph_pkg;

	// Bus and register widths
	localparam int ADDR_W    = 28;
	localparam int DATA_W    = 32;
	localparam int REG_IDX_W = 2;
	localparam int TCNT_W    = 16;
	localparam int WTCNT_W   = 8;
	localparam int LVL_W     = 4;
	localparam int VEC_W     = 8;

	// 16-byte blocks, matched on address bits 27:4
	localparam logic [ADDR_W-1:0] ITU_BASE  = 28'h5FFFF00;
	localparam logic [ADDR_W-1:0] INTC_BASE = 28'h5FFFF80;
	localparam logic [ADDR_W-1:0] WDT_BASE  = 28'h5FFFFB0;

	localparam logic [REG_IDX_W-1:0] ITU_TCR   = 2'd0;
	localparam logic [REG_IDX_W-1:0] ITU_TSR   = 2'd1;
	localparam logic [REG_IDX_W-1:0] ITU_TCNT  = 2'd2;
	localparam logic [REG_IDX_W-1:0] ITU_GRA   = 2'd3;
	localparam logic [REG_IDX_W-1:0] INTC_IPR  = 2'd1;
	localparam logic [REG_IDX_W-1:0] WDT_WTCSR = 2'd2;
	localparam logic [REG_IDX_W-1:0] WDT_WTCNT = 2'd3;

	// Expected in write data bits 15:8
	localparam logic [7:0] WTCNT_KEY = 8'h5A;
	localparam logic [7:0] WTCSR_KEY = 8'hA5;

	localparam logic [VEC_W-1:0] VEC_IMIA = 8'd80;
	localparam logic [VEC_W-1:0] VEC_OVI  = 8'd82;
	localparam logic [VEC_W-1:0] VEC_ITI  = 8'd112;

	// Prescaler tick strobes
	localparam int TICK_N = 7;
	typedef logic [TICK_N-1:0] tick_t;

	localparam int TICK_DIV2    = 0;
	localparam int TICK_DIV4    = 1;
	localparam int TICK_DIV8    = 2;
	localparam int TICK_DIV64   = 3;
	localparam int TICK_DIV256  = 4;
	localparam int TICK_DIV1024 = 5;
	localparam int TICK_DIV8192 = 6;

	// Length of the WDTOVF_N low pulse in cycles
	localparam int WDT_OVF_PULSE = 128;
	localparam int PULSE_CNT_W   = $clog2(WDT_OVF_PULSE);

	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_ITU,
		SEL_INTC,
		SEL_WDT
	} periph_sel_t;

	typedef enum logic {
		WDT_RUN,
		WDT_PULSE
	} wdt_state_t;

endpackage

`default_nettype wire

/* hw/sh_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_periph_top (
	input  logic                             CLK,
	input  logic                             RST_N,
	input  logic                             res_n,
	input  logic                             ibus_req,
	input  logic                             ibus_we,
	input  logic [sh_periph_pkg::ADDR_W-1:0] ibus_addr,
	input  logic [sh_periph_pkg::DATA_W-1:0] ibus_wdata,
	input  logic [sh_periph_pkg::LVL_W-1:0]  int_mask,
	output logic [sh_periph_pkg::DATA_W-1:0] ibus_rdata,
	output logic                             int_req,
	output logic [sh_periph_pkg::LVL_W-1:0]  int_lvl,
	output logic [sh_periph_pkg::VEC_W-1:0]  int_vec,
	output logic                             wdtovf_n
);
	import sh_periph_pkg::*;

	logic                 res_sync_n;
	tick_t                ticks;
	logic [REG_IDX_W-1:0] reg_idx;
	logic [DATA_W-1:0]    wdata;
	logic [DATA_W-1:0]    itu_rdata;
	logic [DATA_W-1:0]    intc_rdata;
	logic [DATA_W-1:0]    wdt_rdata;
	logic                 itu_rd;
	logic                 itu_wr;
	logic                 intc_rd;
	logic                 intc_wr;
	logic                 wdt_rd;
	logic                 wdt_wr;
	logic                 imia_irq;
	logic                 ovi_irq;
	logic                 iti_irq;

	sh_clock_reset i_clock_reset (
		.CLK(CLK), .RST_N(RST_N), .res_n(res_n),
		.res_sync_n(res_sync_n), .ticks(ticks)
	);

	sh_ibus_ctrl i_ibus_ctrl (
		.CLK(CLK), .RST_N(RST_N),
		.ibus_req(ibus_req), .ibus_we(ibus_we),
		.ibus_addr(ibus_addr), .ibus_wdata(ibus_wdata),
		.itu_rdata(itu_rdata), .intc_rdata(intc_rdata), .wdt_rdata(wdt_rdata),
		.ibus_rdata(ibus_rdata), .reg_idx(reg_idx), .wdata(wdata),
		.itu_rd(itu_rd), .itu_wr(itu_wr),
		.intc_rd(intc_rd), .intc_wr(intc_wr),
		.wdt_rd(wdt_rd), .wdt_wr(wdt_wr)
	);

	sh_itu_timer i_itu_timer (
		.CLK(CLK), .RST_N(RST_N), .res_sync_n(res_sync_n), .ticks(ticks),
		.rd(itu_rd), .wr(itu_wr), .reg_idx(reg_idx), .wdata(wdata),
		.rdata(itu_rdata), .imia_irq(imia_irq), .ovi_irq(ovi_irq)
	);

	sh_wdt i_wdt (
		.CLK(CLK), .RST_N(RST_N), .res_sync_n(res_sync_n), .ticks(ticks),
		.rd(wdt_rd), .wr(wdt_wr), .reg_idx(reg_idx), .wdata(wdata),
		.rdata(wdt_rdata), .iti_irq(iti_irq), .wdtovf_n(wdtovf_n)
	);

	sh_intc i_intc (
		.CLK(CLK), .RST_N(RST_N), .res_sync_n(res_sync_n),
		.rd(intc_rd), .wr(intc_wr), .reg_idx(reg_idx), .wdata(wdata),
		.imia_irq(imia_irq), .ovi_irq(ovi_irq), .iti_irq(iti_irq),
		.int_mask(int_mask), .rdata(intc_rdata),
		.int_req(int_req), .int_lvl(int_lvl), .int_vec(int_vec)
	);

endmodule

`default_nettype wire

/* hw/sh_wdt.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_wdt (
	input  logic                                CLK,
	input  logic                                RST_N,
	input  logic                                res_sync_n,
	input  sh_periph_pkg::tick_t                ticks,
	input  logic                                rd,
	input  logic                                wr,
	input  logic [sh_periph_pkg::REG_IDX_W-1:0] reg_idx,
	input  logic [sh_periph_pkg::DATA_W-1:0]    wdata,
	output logic [sh_periph_pkg::DATA_W-1:0]    rdata,
	output logic                                iti_irq,
	output logic                                wdtovf_n
);
	import sh_periph_pkg::*;

	wdt_state_t             state;
	logic [PULSE_CNT_W-1:0] pulse_cnt;
	logic                   ovf;
	logic                   wt_it;
	logic                   tme;
	logic [1:0]             cks;
	logic [WTCNT_W-1:0]     wtcnt;
	logic                   tick_en;
	logic                   wrap;
	logic                   csr_wr;
	logic                   cnt_wr;

	always_comb begin
		case (cks)
			2'd0:    tick_en = ticks[TICK_DIV64];
			2'd1:    tick_en = ticks[TICK_DIV256];
			2'd2:    tick_en = ticks[TICK_DIV1024];
			default: tick_en = ticks[TICK_DIV8192];
		endcase
	end

	assign csr_wr = wr && reg_idx == WDT_WTCSR && wdata[15:8] == WTCSR_KEY;
	assign cnt_wr = wr && reg_idx == WDT_WTCNT && wdata[15:8] == WTCNT_KEY;
	assign wrap   = tme && tick_en && &wtcnt && !cnt_wr;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			{ovf, wt_it, tme, cks} <= '0;
			wtcnt     <= '0;
			state     <= WDT_RUN;
			pulse_cnt <= '0;
			wdtovf_n  <= 1'b1;
		end else if (!res_sync_n) begin
			{ovf, wt_it, tme, cks} <= '0;
			wtcnt     <= '0;
			state     <= WDT_RUN;
			pulse_cnt <= '0;
			wdtovf_n  <= 1'b1;
		end else begin
			if (csr_wr) begin
				ovf   <= ovf & wdata[7];
				wt_it <= wdata[6];
				tme   <= wdata[5];
				cks   <= wdata[1:0];
			end
			if (cnt_wr) begin
				wtcnt <= wdata[WTCNT_W-1:0];
			end else if (tme && tick_en) begin
				wtcnt <= wtcnt + 1'b1;
			end
			if (wrap) begin
				ovf <= 1'b1;
			end
			case (state)
				WDT_RUN: begin
					if (wrap && wt_it) begin
						state     <= WDT_PULSE;
						pulse_cnt <= '0;
						wdtovf_n  <= 1'b0;
					end
				end
				default: begin
					if (pulse_cnt == PULSE_CNT_W'(WDT_OVF_PULSE - 1)) begin
						state    <= WDT_RUN;
						wdtovf_n <= 1'b1;
					end else begin
						pulse_cnt <= pulse_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (rd) begin
			rdata <= '0;
			if (reg_idx == WDT_WTCSR) begin
				rdata[7:0] <= {ovf, wt_it, tme, 3'b000, cks};
			end else if (reg_idx == WDT_WTCNT) begin
				rdata[WTCNT_W-1:0] <= wtcnt;
			end
		end
	end

	// Interval mode only
	assign iti_irq = ovf & ~wt_it;

	a_ovf_pin_in_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
		!wdtovf_n |-> state == WDT_PULSE);

endmodule

`default_nettype wire

/* sim/sh_periph_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_periph_tb;
	import sh_periph_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int SEED        = 85665;
	// Cycle budget for each of the six tests
	localparam int TEST_CYCLES = 3000;
	localparam int NUM_TESTS   = 6;
	localparam int MARGIN      = 2000;
	localparam int TIMEOUT_NS  = (TEST_CYCLES * NUM_TESTS + MARGIN) * CLK_PERIOD;
	localparam logic [ADDR_W-1:0] UNMAPPED = 28'h5FFFF40;

	logic              CLK;
	logic              RST_N;
	logic              res_n;
	logic              ibus_req;
	logic              ibus_we;
	logic [ADDR_W-1:0] ibus_addr;
	logic [DATA_W-1:0] ibus_wdata;
	logic [LVL_W-1:0]  int_mask;
	logic [DATA_W-1:0] ibus_rdata;
	logic              int_req;
	logic [LVL_W-1:0]  int_lvl;
	logic [VEC_W-1:0]  int_vec;
	logic              wdtovf_n;

	logic               pulse_allowed;
	logic [DATA_W-1:0]  rd_data;
	logic [DATA_W-1:0]  ipr_rnd;
	logic [TCNT_W-1:0]  gra;
	logic [TCNT_W-1:0]  tcnt_pre;
	logic [WTCNT_W-1:0] wtcnt_pre;
	logic [LVL_W-1:0]   lvl_a;
	logic [LVL_W-1:0]   lvl_b;
	logic [LVL_W-1:0]   lvl_hi;
	int                 n;
	int                 low_cycles;

	sh_periph_top i_sh_periph_top (
		.CLK(CLK), .RST_N(RST_N), .res_n(res_n),
		.ibus_req(ibus_req), .ibus_we(ibus_we),
		.ibus_addr(ibus_addr), .ibus_wdata(ibus_wdata),
		.int_mask(int_mask), .ibus_rdata(ibus_rdata),
		.int_req(int_req), .int_lvl(int_lvl), .int_vec(int_vec),
		.wdtovf_n(wdtovf_n)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation timed out");
	end

	a_pin_idle: assert property (@(posedge CLK) disable iff (!RST_N)
		pulse_allowed || wdtovf_n)
		else begin
			$display("[FAIL] %0t: wdtovf_n low outside the pulse test", $time);
			$display("TESTBENCH FAILED");
			$fatal(1, "Unexpected overflow pulse");
		end

	a_known_vec: assert property (@(posedge CLK) disable iff (!RST_N)
		int_req |-> (int_vec == VEC_IMIA || int_vec == VEC_OVI || int_vec == VEC_ITI))
		else begin
			$display("[FAIL] %0t: int_req with unknown vector %0d", $time, int_vec);
			$display("TESTBENCH FAILED");
			$fatal(1, "Bad vector");
		end

	task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		assert (got === exp) else begin
			$display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("[FAIL] %0t: %s", $time, what);
			$display("TESTBENCH FAILED");
			$fatal(1, "Condition failed");
		end
	endtask

	task automatic give_up(input string what);
		$display("Timed out waiting for %s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "Wait limit reached");
	endtask

	function automatic logic [ADDR_W-1:0] reg_addr(input logic [ADDR_W-1:0] base,
		input logic [REG_IDX_W-1:0] idx);
		return {base[ADDR_W-1:4], idx, 2'b00};
	endfunction

	// All bus tasks start and end 2 ns after a rising edge
	task automatic step(input int cycles);
		repeat (cycles) @(posedge CLK);
		#2;
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		ibus_req   = 1'b1;
		ibus_we    = 1'b1;
		ibus_addr  = addr;
		ibus_wdata = data;
		step(1);
		ibus_req = 1'b0;
		ibus_we  = 1'b0;
	endtask

	// Data is valid one cycle after the request
	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		ibus_req  = 1'b1;
		ibus_we   = 1'b0;
		ibus_addr = addr;
		step(1);
		ibus_req = 1'b0;
		data     = ibus_rdata;
	endtask

	task automatic wait_int_req(input logic level, input int max_cycles, input string what);
		int cnt;
		cnt = 0;
		while (int_req !== level && cnt < max_cycles) begin
			step(1);
			cnt++;
		end
		if (int_req !== level) begin
			give_up(what);
		end
	endtask

	task automatic wait_wdt_ovf(input int max_reads);
		logic [DATA_W-1:0] data;
		int cnt;
		data = '0;
		cnt  = 0;
		while (!data[7] && cnt < max_reads) begin
			bus_read(reg_addr(WDT_BASE, WDT_WTCSR), data);
			cnt++;
		end
		if (!data[7]) begin
			give_up("the watchdog OVF flag");
		end
	endtask

	task automatic check_irq(input logic [VEC_W-1:0] vec, input logic [LVL_W-1:0] lvl,
		input string what);
		check_eq(32'(int_req), 32'd1, {what, ": int_req"});
		check_eq(32'(int_vec), 32'(vec), {what, ": int_vec"});
		check_eq(32'(int_lvl), 32'(lvl), {what, ": int_lvl"});
	endtask

	initial begin
		void'($urandom(SEED));
		$timeformat(-9, 0, " ns", 0);
		RST_N         = 1'b0;
		res_n         = 1'b1;
		ibus_req      = 1'b0;
		ibus_we       = 1'b0;
		ibus_addr     = '0;
		ibus_wdata    = '0;
		int_mask      = '0;
		pulse_allowed = 1'b0;
		repeat (2) @(posedge CLK);
		#2;
		RST_N = 1'b1;
		step(2);
		check_eq(32'(int_req), 32'd0, "int_req after reset");
		check_eq(32'(int_lvl), 32'd0, "int_lvl after reset");
		check_eq(32'(int_vec), 32'd0, "int_vec after reset");
		check_eq(32'(wdtovf_n), 32'd1, "wdtovf_n after reset");
		check_eq(ibus_rdata, 32'd0, "ibus_rdata after reset");

		// Readback and unmapped access
		gra     = TCNT_W'(20 + $urandom % 48);
		ipr_rnd = $urandom;
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h34);
		bus_read(reg_addr(ITU_BASE, ITU_TCR), rd_data);
		check_eq(rd_data, 32'h34, "TCR readback");
		bus_write(reg_addr(ITU_BASE, ITU_GRA), 32'(gra));
		bus_read(reg_addr(ITU_BASE, ITU_GRA), rd_data);
		check_eq(rd_data, 32'(gra), "GRA readback");
		bus_write(reg_addr(INTC_BASE, INTC_IPR), ipr_rnd);
		bus_read(reg_addr(INTC_BASE, INTC_IPR), rd_data);
		check_eq(rd_data, {16'h0000, ipr_rnd[15:0]}, "IPR readback");
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h43});
		bus_read(reg_addr(WDT_BASE, WDT_WTCSR), rd_data);
		check_eq(rd_data, 32'h43, "WTCSR readback");
		bus_read(UNMAPPED, rd_data);
		check_eq(rd_data, 32'd0, "unmapped read");
		bus_write(UNMAPPED, 32'hFFFF_FFFF);
		bus_read(reg_addr(ITU_BASE, ITU_TCR), rd_data);
		check_eq(rd_data, 32'h34, "TCR after unmapped write");
		bus_read(reg_addr(ITU_BASE, ITU_GRA), rd_data);
		check_eq(rd_data, 32'(gra), "GRA after unmapped write");
		bus_read(reg_addr(INTC_BASE, INTC_IPR), rd_data);
		check_eq(rd_data, {16'h0000, ipr_rnd[15:0]}, "IPR after unmapped write");
		bus_read(reg_addr(WDT_BASE, WDT_WTCSR), rd_data);
		check_eq(rd_data, 32'h43, "WTCSR after unmapped write");

		// Timer compare match with CCLR and IMIEA on every cycle
		lvl_a = LVL_W'(1 + $urandom % 15);
		bus_write(reg_addr(INTC_BASE, INTC_IPR), {16'h0000, lvl_a, 12'h000});
		bus_write(reg_addr(ITU_BASE, ITU_TCNT), 32'd0);
		bus_write(reg_addr(ITU_BASE, ITU_TSR), 32'd0);
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h1C);
		wait_int_req(1'b1, int'(gra) + 8, "the compare match interrupt");
		check_irq(VEC_IMIA, lvl_a, "compare match");
		bus_read(reg_addr(ITU_BASE, ITU_TSR), rd_data);
		check_eq(32'(rd_data[0]), 32'd1, "IMFA flag");
		for (n = 0; n < 4; n++) begin
			bus_read(reg_addr(ITU_BASE, ITU_TCNT), rd_data);
			check_true(rd_data[TCNT_W-1:0] <= gra, "TCNT above GRA with CCLR set");
		end
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h14);
		bus_write(reg_addr(ITU_BASE, ITU_TSR), 32'd0);
		wait_int_req(1'b0, 4, "int_req to drop after the IMFA clear");

		// Timer overflow
		tcnt_pre = TCNT_W'(16'hFFFF - $urandom % 32);
		bus_write(reg_addr(ITU_BASE, ITU_TCNT), 32'(tcnt_pre));
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h28);
		wait_int_req(1'b1, 64, "the overflow interrupt");
		check_irq(VEC_OVI, lvl_a, "timer overflow");
		bus_read(reg_addr(ITU_BASE, ITU_TSR), rd_data);
		check_eq(32'(rd_data[1]), 32'd1, "timer OVF flag");
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h20);
		bus_write(reg_addr(ITU_BASE, ITU_TSR), 32'd0);
		wait_int_req(1'b0, 4, "int_req to drop after the OVF clear");

		// Watchdog keys and interval interrupt
		bus_write(reg_addr(WDT_BASE, WDT_WTCNT), {16'h0000, WTCNT_KEY, 8'h10});
		bus_read(reg_addr(WDT_BASE, WDT_WTCNT), rd_data);
		check_eq(rd_data, 32'h10, "keyed WTCNT write");
		bus_write(reg_addr(WDT_BASE, WDT_WTCNT), {16'h0000, WTCSR_KEY, 8'h77});
		bus_read(reg_addr(WDT_BASE, WDT_WTCNT), rd_data);
		check_eq(rd_data, 32'h10, "WTCNT write with wrong key");
		lvl_b = LVL_W'(1 + $urandom % 15);
		bus_write(reg_addr(INTC_BASE, INTC_IPR), {16'h0000, lvl_a, lvl_b, 8'h00});
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h00});
		wtcnt_pre = WTCNT_W'(8'hFF - $urandom % 4);
		bus_write(reg_addr(WDT_BASE, WDT_WTCNT), {16'h0000, WTCNT_KEY, wtcnt_pre});
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h20});
		wait_int_req(1'b1, 8 * 64, "the interval interrupt");
		check_irq(VEC_ITI, lvl_b, "interval interrupt");
		bus_read(reg_addr(WDT_BASE, WDT_WTCSR), rd_data);
		check_eq(32'(rd_data[7]), 32'd1, "watchdog OVF flag");
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h00});
		wait_int_req(1'b0, 4, "int_req to drop after the watchdog OVF clear");

		// Watchdog mode overflow pulse
		pulse_allowed = 1'b1;
		bus_write(reg_addr(WDT_BASE, WDT_WTCNT), {16'h0000, WTCNT_KEY, 8'hFE});
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h60});
		n = 0;
		while (wdtovf_n && n < 4 * 64) begin
			step(1);
			n++;
		end
		if (wdtovf_n) begin
			give_up("wdtovf_n to go low");
		end
		low_cycles = 1;
		step(1);
		while (!wdtovf_n && low_cycles < 2 * WDT_OVF_PULSE) begin
			low_cycles++;
			step(1);
		end
		check_eq(32'(low_cycles), 32'(WDT_OVF_PULSE), "wdtovf_n low cycles");
		check_eq(32'(int_req), 32'd0, "int_req in watchdog mode");
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h40});
		step(1);
		pulse_allowed = 1'b0;

		// Priority and mask with both sources pending
		lvl_a = LVL_W'(1 + $urandom % 15);
		lvl_b = lvl_a;
		while (lvl_b == lvl_a) begin
			lvl_b = LVL_W'(1 + $urandom % 15);
		end
		lvl_hi = (lvl_a > lvl_b) ? lvl_a : lvl_b;
		bus_write(reg_addr(INTC_BASE, INTC_IPR), {16'h0000, lvl_a, lvl_b, 8'h00});
		bus_write(reg_addr(ITU_BASE, ITU_TCNT), 32'd0);
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h1C);
		wait_int_req(1'b1, int'(gra) + 8, "the timer to become pending");
		bus_write(reg_addr(ITU_BASE, ITU_TCR), 32'h14);
		bus_write(reg_addr(WDT_BASE, WDT_WTCNT), {16'h0000, WTCNT_KEY, 8'hFF});
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h20});
		wait_wdt_ovf(100);
		// Stop counting and keep OVF set by writing it as 1
		bus_write(reg_addr(WDT_BASE, WDT_WTCSR), {16'h0000, WTCSR_KEY, 8'h80});
		step(2);
		check_irq((lvl_a > lvl_b) ? VEC_IMIA : VEC_ITI, lvl_hi, "higher level wins");
		int_mask = lvl_hi - 4'd1;
		step(2);
		check_irq((lvl_a > lvl_b) ? VEC_IMIA : VEC_ITI, lvl_hi, "mask below winner");
		int_mask = lvl_hi;
		step(2);
		check_eq(32'(int_req), 32'd0, "int_req with mask at the top level");
		int_mask = '0;
		bus_write(reg_addr(INTC_BASE, INTC_IPR), {16'h0000, lvl_b, lvl_a, 8'h00});
		step(2);
		check_irq((lvl_b > lvl_a) ? VEC_IMIA : VEC_ITI, lvl_hi, "swapped levels");

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
